//--- verilog/mips_pkg.sv
package mips_pkg;

    // widths with a meaning of their own
    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [4:0]  reg_idx_t;

    // primary opcode field, bits 31:26
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,
        OP_ADDIU   = 6'b001001,
        OP_LW      = 6'b100011,
        OP_SW      = 6'b101011
    } opcode_t;

    // funct field of the special group
    localparam logic [5:0] FUNCT_JR = 6'b001000;

    // first instruction after the zero word
    localparam addr_t RESET_PC = 32'h0000_0004;

    // master to slave
    typedef struct packed {
        logic       aw_valid;
        addr_t      aw_addr;
        logic       w_valid;
        word_t      w_data;
        logic [3:0] w_strb;
        logic       b_ready;
        logic       ar_valid;
        addr_t      ar_addr;
        logic       r_ready;
    } axil_req_t;

    // slave to master, responses are always OKAY
    typedef struct packed {
        logic  aw_ready;
        logic  w_ready;
        logic  b_valid;
        logic  ar_ready;
        logic  r_valid;
        word_t r_data;
    } axil_rsp_t;

    typedef enum logic [2:0] {
        CORE_IDLE,
        CORE_WAIT_INSTR,
        CORE_EXEC,
        CORE_MEM_WAIT,
        CORE_HALTED
    } core_state_t;

    typedef enum logic [1:0] {
        ARB_FREE,
        ARB_BUSY_READ,
        ARB_BUSY_WRITE
    } arb_state_t;

endpackage

//--- verilog/unified_ram.sv
`timescale 1ns/1ps

module unified_ram #(
    parameter int MEM_WORDS = 1024
) (
    input  logic                clk,
    input  logic                arst_n,
    input  mips_pkg::axil_req_t req,
    output mips_pkg::axil_rsp_t rsp
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    mips_pkg::word_t mem [MEM_WORDS];

    logic            r_valid_q;
    logic            b_valid_q;
    mips_pkg::word_t r_data_q;
    logic            idle;
    logic            wr_go;
    logic            rd_go;
    logic [IDX_W-1:0] wr_idx;
    logic [IDX_W-1:0] rd_idx;

    // i-type word from its fields
    function automatic mips_pkg::word_t itype(
        mips_pkg::opcode_t  op,
        mips_pkg::reg_idx_t rs,
        mips_pkg::reg_idx_t rt,
        logic [15:0]        imm
    );
        return {op, rs, rt, imm};
    endfunction

    // test program at 0x4: 30 lw, 30 addiu, 30 sw, then jr r0
    initial begin
        int w;
        for (int k = 0; k < MEM_WORDS; k++) begin
            mem[k] = '0;
        end
        w = 1;
        for (int r = 2; r < 32; r++) begin
            mem[w] = itype(mips_pkg::OP_LW, 5'd0, 5'(r), 16'(16'h0400 + (r - 2) * 4));
            w++;
        end
        for (int r = 2; r < 32; r++) begin
            mem[w] = itype(mips_pkg::OP_ADDIU, 5'(r), 5'(r), 16'h0001);
            w++;
        end
        for (int r = 2; r < 32; r++) begin
            mem[w] = itype(mips_pkg::OP_SW, 5'd0, 5'(r), 16'(16'h0480 + (r - 2) * 4));
            w++;
        end
        mem[w] = {mips_pkg::OP_SPECIAL, 5'd0, 15'd0, mips_pkg::FUNCT_JR};
    end

    // word index, address wraps at the memory size
    assign wr_idx = req.aw_addr[IDX_W+1:2];
    assign rd_idx = req.ar_addr[IDX_W+1:2];

    // one transfer at a time, writes win a tie
    assign idle  = !r_valid_q && !b_valid_q;
    assign wr_go = idle && req.aw_valid && req.w_valid;
    assign rd_go = idle && req.ar_valid && !wr_go;

    assign rsp.aw_ready = wr_go;
    assign rsp.w_ready  = wr_go;
    assign rsp.ar_ready = idle && !(req.aw_valid && req.w_valid);
    assign rsp.b_valid  = b_valid_q;
    assign rsp.r_valid  = r_valid_q;
    assign rsp.r_data   = r_data_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            r_valid_q <= 1'b0;
            b_valid_q <= 1'b0;
        end else begin
            if (rd_go) begin
                r_valid_q <= 1'b1;
            end else if (r_valid_q && req.r_ready) begin
                r_valid_q <= 1'b0;
            end
            if (wr_go) begin
                b_valid_q <= 1'b1;
            end else if (b_valid_q && req.b_ready) begin
                b_valid_q <= 1'b0;
            end
        end
    end

    // array and read data
    always_ff @(posedge clk) begin
        if (rd_go) begin
            r_data_q <= mem[rd_idx];
        end
        if (wr_go) begin
            for (int b = 0; b < 4; b++) begin
                if (req.w_strb[b]) begin
                    mem[wr_idx][8*b +: 8] <= req.w_data[8*b +: 8];
                end
            end
        end
    end

endmodule

//--- verilog/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                redirect,
    input  mips_pkg::addr_t     redirect_pc,
    output logic                instr_valid,
    output mips_pkg::word_t     instr,
    output mips_pkg::addr_t     instr_pc,
    input  logic                instr_take,
    output mips_pkg::axil_req_t bus_req,
    input  mips_pkg::axil_rsp_t bus_rsp
);

    logic            active_q;
    logic            ar_valid_q;
    logic            in_flight_q;
    logic            stale_q;
    logic            buf_valid_q;
    mips_pkg::addr_t pc_q;
    mips_pkg::addr_t ar_addr_q;
    mips_pkg::addr_t buf_pc_q;
    mips_pkg::word_t buf_data_q;

    logic ar_done;
    logic r_done;
    logic issue;
    logic fill;

    assign ar_done = ar_valid_q && bus_rsp.ar_ready;
    assign r_done  = in_flight_q && bus_rsp.r_valid;

    // one read outstanding, started when the buffer is empty or leaving
    assign issue = active_q && !redirect && !ar_valid_q && !in_flight_q &&
                   (!buf_valid_q || instr_take);
    assign fill  = r_done && !stale_q && !redirect;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            active_q    <= 1'b0;
            ar_valid_q  <= 1'b0;
            in_flight_q <= 1'b0;
            stale_q     <= 1'b0;
            buf_valid_q <= 1'b0;
            pc_q        <= '0;
        end else begin
            if (ar_done) begin
                ar_valid_q  <= 1'b0;
                in_flight_q <= 1'b1;
            end
            if (r_done) begin
                in_flight_q <= 1'b0;
                stale_q     <= 1'b0;
            end
            if (issue) begin
                ar_valid_q <= 1'b1;
                pc_q       <= pc_q + 32'd4;
            end
            if (instr_take) begin
                buf_valid_q <= 1'b0;
            end
            if (fill) begin
                buf_valid_q <= 1'b1;
            end
            if (redirect) begin
                active_q    <= 1'b1;
                pc_q        <= redirect_pc;
                buf_valid_q <= 1'b0;
                // a read still on the bus belongs to the old path
                stale_q     <= (ar_valid_q || in_flight_q) && !r_done;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            ar_addr_q <= pc_q;
        end
        if (fill) begin
            buf_data_q <= bus_rsp.r_data;
            buf_pc_q   <= ar_addr_q;
        end
    end

    assign instr_valid = buf_valid_q;
    assign instr       = buf_data_q;
    assign instr_pc    = buf_pc_q;

    // read-only master
    always_comb begin
        bus_req          = '0;
        bus_req.ar_valid = ar_valid_q;
        bus_req.ar_addr  = ar_addr_q;
        bus_req.r_ready  = in_flight_q;
    end

endmodule

//--- verilog/exec_core.sv
`timescale 1ns/1ps

module exec_core (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                start,
    output logic                halted,
    input  logic                instr_valid,
    input  mips_pkg::word_t     instr,
    output logic                instr_take,
    output logic                redirect,
    output mips_pkg::addr_t     redirect_pc,
    output mips_pkg::axil_req_t bus_req,
    input  mips_pkg::axil_rsp_t bus_rsp
);

    mips_pkg::core_state_t state_q;
    mips_pkg::word_t       ir_q;
    mips_pkg::word_t       rf [32];

    logic            ar_valid_q;
    logic            aw_valid_q;
    logic            w_valid_q;
    mips_pkg::addr_t addr_q;
    mips_pkg::word_t wdata_q;

    // decoded fields
    mips_pkg::opcode_t  op;
    mips_pkg::reg_idx_t rs;
    mips_pkg::reg_idx_t rt;
    logic [5:0]         funct;
    mips_pkg::word_t    simm;
    mips_pkg::word_t    rs_val;
    mips_pkg::word_t    rt_val;
    mips_pkg::addr_t    eff_addr;

    logic               in_exec;
    logic               is_jr;
    logic               r_done;
    logic               b_done;
    logic               restart;
    logic               rf_we;
    mips_pkg::word_t    rf_wdata;

    assign op       = mips_pkg::opcode_t'(ir_q[31:26]);
    assign rs       = ir_q[25:21];
    assign rt       = ir_q[20:16];
    assign funct    = ir_q[5:0];
    assign simm     = {{16{ir_q[15]}}, ir_q[15:0]};

    // r0 always reads zero
    assign rs_val   = (rs == '0) ? '0 : rf[rs];
    assign rt_val   = (rt == '0) ? '0 : rf[rt];
    assign eff_addr = rs_val + simm;

    assign in_exec  = (state_q == mips_pkg::CORE_EXEC);
    assign is_jr    = (op == mips_pkg::OP_SPECIAL) && (funct == mips_pkg::FUNCT_JR);
    assign r_done   = (state_q == mips_pkg::CORE_MEM_WAIT) && bus_rsp.r_valid;
    assign b_done   = (state_q == mips_pkg::CORE_MEM_WAIT) && bus_rsp.b_valid;
    assign restart  = start && (state_q == mips_pkg::CORE_IDLE ||
                                state_q == mips_pkg::CORE_HALTED);

    assign instr_take = (state_q == mips_pkg::CORE_WAIT_INSTR) && instr_valid;
    assign halted     = (state_q == mips_pkg::CORE_HALTED);

    // start goes to 0x4, a nonzero jr goes to its target
    assign redirect    = restart || (in_exec && is_jr && rs_val != '0);
    assign redirect_pc = restart ? mips_pkg::RESET_PC : rs_val;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q    <= mips_pkg::CORE_IDLE;
            ar_valid_q <= 1'b0;
            aw_valid_q <= 1'b0;
            w_valid_q  <= 1'b0;
        end else begin
            case (state_q)
                mips_pkg::CORE_IDLE, mips_pkg::CORE_HALTED: begin
                    if (start) begin
                        state_q <= mips_pkg::CORE_WAIT_INSTR;
                    end
                end
                mips_pkg::CORE_WAIT_INSTR: begin
                    if (instr_valid) begin
                        state_q <= mips_pkg::CORE_EXEC;
                    end
                end
                mips_pkg::CORE_EXEC: begin
                    case (op)
                        mips_pkg::OP_LW: begin
                            ar_valid_q <= 1'b1;
                            state_q    <= mips_pkg::CORE_MEM_WAIT;
                        end
                        mips_pkg::OP_SW: begin
                            aw_valid_q <= 1'b1;
                            w_valid_q  <= 1'b1;
                            state_q    <= mips_pkg::CORE_MEM_WAIT;
                        end
                        default: begin
                            // jr r0 stops here, unknown encodings retire as nops
                            if (is_jr && rs_val == '0) begin
                                state_q <= mips_pkg::CORE_HALTED;
                            end else begin
                                state_q <= mips_pkg::CORE_WAIT_INSTR;
                            end
                        end
                    endcase
                end
                mips_pkg::CORE_MEM_WAIT: begin
                    if (ar_valid_q && bus_rsp.ar_ready) begin
                        ar_valid_q <= 1'b0;
                    end
                    if (aw_valid_q && bus_rsp.aw_ready) begin
                        aw_valid_q <= 1'b0;
                    end
                    if (w_valid_q && bus_rsp.w_ready) begin
                        w_valid_q <= 1'b0;
                    end
                    if (r_done || b_done) begin
                        state_q <= mips_pkg::CORE_WAIT_INSTR;
                    end
                end
                default: state_q <= mips_pkg::CORE_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (instr_take) begin
            ir_q <= instr;
        end
        if (in_exec) begin
            addr_q  <= eff_addr;
            wdata_q <= rt_val;
        end
    end

    // addiu result or load data, both into rt
    assign rf_we    = (in_exec && op == mips_pkg::OP_ADDIU) || r_done;
    assign rf_wdata = in_exec ? rs_val + simm : bus_rsp.r_data;

    always_ff @(posedge clk) begin
        if (rf_we) begin
            rf[rt] <= rf_wdata;
        end
    end

    always_comb begin
        bus_req          = '0;
        bus_req.ar_valid = ar_valid_q;
        bus_req.ar_addr  = addr_q;
        bus_req.aw_valid = aw_valid_q;
        bus_req.aw_addr  = addr_q;
        bus_req.w_valid  = w_valid_q;
        bus_req.w_data   = wdata_q;
        bus_req.w_strb   = 4'hF;
        bus_req.r_ready  = (state_q == mips_pkg::CORE_MEM_WAIT);
        bus_req.b_ready  = (state_q == mips_pkg::CORE_MEM_WAIT);
    end

endmodule

//--- verilog/axi_lite_arbiter.sv
`timescale 1ns/1ps

module axi_lite_arbiter (
    input  logic                clk,
    input  logic                arst_n,
    input  mips_pkg::axil_req_t dbg_req,
    output mips_pkg::axil_rsp_t dbg_rsp,
    input  mips_pkg::axil_req_t data_req,
    output mips_pkg::axil_rsp_t data_rsp,
    input  mips_pkg::axil_req_t fetch_req,
    output mips_pkg::axil_rsp_t fetch_rsp,
    output mips_pkg::axil_req_t mem_req,
    input  mips_pkg::axil_rsp_t mem_rsp
);

    // one-hot grant
    localparam logic [2:0] GNT_DBG   = 3'b001;
    localparam logic [2:0] GNT_DATA  = 3'b010;
    localparam logic [2:0] GNT_FETCH = 3'b100;

    mips_pkg::arb_state_t state_q;
    logic [2:0]           grant_q;
    logic [2:0]           grant_d;
    logic                 sel_write;

    function automatic logic wants(mips_pkg::axil_req_t r);
        return r.ar_valid || r.aw_valid || r.w_valid;
    endfunction

    // fixed priority: debug, data, fetch
    always_comb begin
        grant_d   = '0;
        sel_write = 1'b0;
        if (wants(dbg_req)) begin
            grant_d   = GNT_DBG;
            sel_write = dbg_req.aw_valid;
        end else if (wants(data_req)) begin
            grant_d   = GNT_DATA;
            sel_write = data_req.aw_valid;
        end else if (wants(fetch_req)) begin
            grant_d   = GNT_FETCH;
            sel_write = fetch_req.aw_valid;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= mips_pkg::ARB_FREE;
            grant_q <= '0;
        end else begin
            case (state_q)
                mips_pkg::ARB_FREE: begin
                    if (grant_d != '0) begin
                        grant_q <= grant_d;
                        state_q <= sel_write ? mips_pkg::ARB_BUSY_WRITE
                                             : mips_pkg::ARB_BUSY_READ;
                    end
                end
                mips_pkg::ARB_BUSY_READ: begin
                    if (mem_rsp.r_valid && mem_req.r_ready) begin
                        grant_q <= '0;
                        state_q <= mips_pkg::ARB_FREE;
                    end
                end
                mips_pkg::ARB_BUSY_WRITE: begin
                    if (mem_rsp.b_valid && mem_req.b_ready) begin
                        grant_q <= '0;
                        state_q <= mips_pkg::ARB_FREE;
                    end
                end
                default: begin
                    grant_q <= '0;
                    state_q <= mips_pkg::ARB_FREE;
                end
            endcase
        end
    end

    // masters without the grant see all zero
    always_comb begin
        mem_req   = '0;
        dbg_rsp   = '0;
        data_rsp  = '0;
        fetch_rsp = '0;
        case (grant_q)
            GNT_DBG: begin
                mem_req = dbg_req;
                dbg_rsp = mem_rsp;
            end
            GNT_DATA: begin
                mem_req  = data_req;
                data_rsp = mem_rsp;
            end
            GNT_FETCH: begin
                mem_req   = fetch_req;
                fetch_rsp = mem_rsp;
            end
            default: ;
        endcase
    end

endmodule

//--- verilog/mips_lite_top.sv
`timescale 1ns/1ps

module mips_lite_top #(
    parameter int MEM_WORDS = 1024
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                start,
    output logic                halted,
    input  mips_pkg::axil_req_t dbg_req,
    output mips_pkg::axil_rsp_t dbg_rsp
);

    // core to fetch
    logic                redirect;
    mips_pkg::addr_t     redirect_pc;
    logic                instr_valid;
    mips_pkg::word_t     instr;
    logic                instr_take;

    // bus links
    mips_pkg::axil_req_t fetch_req;
    mips_pkg::axil_rsp_t fetch_rsp;
    mips_pkg::axil_req_t data_req;
    mips_pkg::axil_rsp_t data_rsp;
    mips_pkg::axil_req_t mem_req;
    mips_pkg::axil_rsp_t mem_rsp;

    exec_core u_core (
        .clk         (clk),
        .arst_n      (arst_n),
        .start       (start),
        .halted      (halted),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_take  (instr_take),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .bus_req     (data_req),
        .bus_rsp     (data_rsp)
    );

    // the buffered word's pc is not needed by the core
    fetch_unit u_fetch (
        .clk         (clk),
        .arst_n      (arst_n),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_pc    (),
        .instr_take  (instr_take),
        .bus_req     (fetch_req),
        .bus_rsp     (fetch_rsp)
    );

    axi_lite_arbiter u_arb (
        .clk       (clk),
        .arst_n    (arst_n),
        .dbg_req   (dbg_req),
        .dbg_rsp   (dbg_rsp),
        .data_req  (data_req),
        .data_rsp  (data_rsp),
        .fetch_req (fetch_req),
        .fetch_rsp (fetch_rsp),
        .mem_req   (mem_req),
        .mem_rsp   (mem_rsp)
    );

    unified_ram #(
        .MEM_WORDS (MEM_WORDS)
    ) u_ram (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (mem_req),
        .rsp    (mem_rsp)
    );

endmodule

//--- verification/mips_lite_properties.sv
`timescale 1ns/1ps

module mips_lite_properties (
    input logic                 clk,
    input logic                 arst_n,
    input logic [2:0]           grant_q,
    input mips_pkg::axil_req_t  mem_req,
    input mips_pkg::axil_rsp_t  mem_rsp,
    input mips_pkg::axil_rsp_t  dbg_rsp,
    input mips_pkg::axil_rsp_t  data_rsp,
    input mips_pkg::axil_rsp_t  fetch_rsp
);

    grant_onehot: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(grant_q))
        else $error("more than one master holds the grant");

    ar_stable: assert property (@(posedge clk) disable iff (!arst_n)
        (mem_req.ar_valid && !mem_rsp.ar_ready) |=>
            (mem_req.ar_valid && $stable(mem_req.ar_addr)))
        else $error("read address dropped or changed before ar ready");

    aw_stable: assert property (@(posedge clk) disable iff (!arst_n)
        (mem_req.aw_valid && !mem_rsp.aw_ready) |=>
            (mem_req.aw_valid && mem_req.w_valid && $stable(mem_req.aw_addr)))
        else $error("write request dropped or changed before aw ready");

    // masters without the grant see an all-zero response
    dbg_quiet: assert property (@(posedge clk) disable iff (!arst_n)
        (grant_q != 3'b001) |-> (dbg_rsp == '0))
        else $error("debug port got a response without the grant");

    data_quiet: assert property (@(posedge clk) disable iff (!arst_n)
        (grant_q != 3'b010) |-> (data_rsp == '0))
        else $error("data port got a response without the grant");

    fetch_quiet: assert property (@(posedge clk) disable iff (!arst_n)
        (grant_q != 3'b100) |-> (fetch_rsp == '0))
        else $error("fetch port got a response without the grant");

endmodule

bind axi_lite_arbiter mips_lite_properties u_props (
    .clk       (clk),
    .arst_n    (arst_n),
    .grant_q   (grant_q),
    .mem_req   (mem_req),
    .mem_rsp   (mem_rsp),
    .dbg_rsp   (dbg_rsp),
    .data_rsp  (data_rsp),
    .fetch_rsp (fetch_rsp)
);

//--- verification/tb_mips_lite.sv
`timescale 1ns/1ps

module tb_mips_lite;

    localparam int          CYCLE_LIMIT = 20000;
    localparam int          N_WORDS     = 30;
    localparam int          PROG_WORDS  = 91;
    localparam logic [31:0] DATA_BASE   = 32'h0000_0400;
    localparam logic [31:0] RESULT_BASE = 32'h0000_0480;
    localparam logic [31:0] SCRATCH     = 32'h0000_0800;

    // mips encodings
    localparam logic [5:0]  OPC_LW    = 6'h23;
    localparam logic [5:0]  OPC_SW    = 6'h2b;
    localparam logic [5:0]  OPC_ADDIU = 6'h09;
    localparam logic [31:0] JR_R0     = 32'h0000_0008;

    logic                clk;
    logic                arst_n;
    logic                start;
    logic                halted;
    mips_pkg::axil_req_t dbg_req;
    mips_pkg::axil_rsp_t dbg_rsp;

    int          errors;
    int          checks;
    int          cycles;
    logic [31:0] rng_state;
    logic [31:0] loaded [N_WORDS];

    mips_lite_top #(
        .MEM_WORDS (1024)
    ) DUT (
        .clk     (clk),
        .arst_n  (arst_n),
        .start   (start),
        .halted  (halted),
        .dbg_req (dbg_req),
        .dbg_rsp (dbg_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] itype_word(input logic [5:0] op, input logic [4:0] rs,
                                               input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // expected memory word at index idx of the built-in program
    function automatic logic [31:0] program_word(input int idx, input logic [15:0] add_imm);
        logic [4:0]  r;
        logic [31:0] w;
        w = '0;
        if (idx >= 1 && idx <= 30) begin
            r = 5'(idx + 1);
            w = itype_word(OPC_LW, 5'd0, r, 16'(DATA_BASE + 4 * (idx - 1)));
        end else if (idx >= 31 && idx <= 60) begin
            r = 5'(idx - 29);
            w = itype_word(OPC_ADDIU, r, r, add_imm);
        end else if (idx >= 61 && idx <= 90) begin
            r = 5'(idx - 59);
            w = itype_word(OPC_SW, 5'd0, r, 16'(RESULT_BASE + 4 * (idx - 61)));
        end else if (idx == 91) begin
            w = JR_R0;
        end
        return w;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                                input logic [31:0] next_w,
                                                input logic [3:0]  strb);
        logic [31:0] m;
        m = old_w;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                m[8*b +: 8] = next_w[8*b +: 8];
            end
        end
        return m;
    endfunction

    task automatic draw_random(output logic [31:0] w);
        rng_state = xorshift32(rng_state);
        w = rng_state;
    endtask

    task automatic check_word(input string name, input logic [31:0] exp,
                              input logic [31:0] got);
        checks++;
        assert (got === exp)
        else begin
            errors++;
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, got);
        end
    endtask

    // debug master, AW and W together, then B
    task automatic dbg_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
        @(negedge clk);
        dbg_req.aw_valid = 1'b1;
        dbg_req.aw_addr  = addr;
        dbg_req.w_valid  = 1'b1;
        dbg_req.w_data   = data;
        dbg_req.w_strb   = strb;
        dbg_req.b_ready  = 1'b1;
        @(negedge clk);
        while (!dbg_rsp.aw_ready) @(negedge clk);
        // aw and w are taken together on the next rising edge
        check_word("dbg_rsp.w_ready", 32'd1, {31'd0, dbg_rsp.w_ready});
        @(negedge clk);
        dbg_req.aw_valid = 1'b0;
        dbg_req.w_valid  = 1'b0;
        while (!dbg_rsp.b_valid) @(negedge clk);
        @(negedge clk);
        dbg_req.b_ready = 1'b0;
    endtask

    task automatic dbg_read(input logic [31:0] addr, output logic [31:0] data);
        @(negedge clk);
        dbg_req.ar_valid = 1'b1;
        dbg_req.ar_addr  = addr;
        dbg_req.r_ready  = 1'b1;
        @(negedge clk);
        while (!dbg_rsp.ar_ready) @(negedge clk);
        @(negedge clk);
        dbg_req.ar_valid = 1'b0;
        while (!dbg_rsp.r_valid) @(negedge clk);
        data = dbg_rsp.r_data;
        @(negedge clk);
        dbg_req.r_ready = 1'b0;
    endtask

    task automatic pulse_start();
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic wait_halted();
        while (!halted) @(negedge clk);
    endtask

    task automatic load_random_data();
        for (int k = 0; k < N_WORDS; k++) begin
            draw_random(loaded[k]);
            dbg_write(DATA_BASE + 4 * k, loaded[k], 4'hF);
        end
    endtask

    // every result is its loaded word plus delta, modulo 2**32
    task automatic check_results(input logic [31:0] delta);
        logic [31:0] got;
        for (int k = 0; k < N_WORDS; k++) begin
            dbg_read(RESULT_BASE + 4 * k, got);
            check_word($sformatf("dbg_rsp.r_data @%h", RESULT_BASE + 4 * k),
                       loaded[k] + delta, got);
        end
    endtask

    task automatic test_reset_and_debug();
        logic [31:0] base;
        logic [31:0] patch;
        logic [31:0] got;
        check_word("halted", 32'd0, {31'd0, halted});
        check_word("dbg_rsp.r_valid", 32'd0, {31'd0, dbg_rsp.r_valid});
        check_word("dbg_rsp.b_valid", 32'd0, {31'd0, dbg_rsp.b_valid});
        draw_random(base);
        dbg_write(SCRATCH, base, 4'hF);
        dbg_read(SCRATCH, got);
        check_word("dbg_rsp.r_data", base, got);
        draw_random(patch);
        dbg_write(SCRATCH, patch, 4'b0101);
        dbg_read(SCRATCH, got);
        check_word("dbg_rsp.r_data", merge_bytes(base, patch, 4'b0101), got);
    endtask

    task automatic test_builtin_program();
        load_random_data();
        pulse_start();
        wait_halted();
        check_results(32'd1);
    endtask

    task automatic test_sign_extension();
        for (int idx = 31; idx <= 60; idx++) begin
            dbg_write(4 * idx, program_word(idx, 16'hFFFF), 4'hF);
        end
        load_random_data();
        pulse_start();
        wait_halted();
        check_results(32'hFFFF_FFFF);
    endtask

    task automatic test_early_halt();
        dbg_write(32'h0000_0004, JR_R0, 4'hF);
        for (int k = 0; k < N_WORDS; k++) begin
            loaded[k] = '0;
            dbg_write(RESULT_BASE + 4 * k, 32'd0, 4'hF);
        end
        pulse_start();
        wait_halted();
        check_results(32'd0);
    endtask

    task automatic test_contention();
        logic [31:0] got;
        int          idx;
        for (int i = 1; i <= PROG_WORDS; i++) begin
            dbg_write(4 * i, program_word(i, 16'h0001), 4'hF);
        end
        load_random_data();
        pulse_start();
        idx = 1;
        // code reads compete with fetch and load/store traffic
        while (!halted) begin
            dbg_read(4 * idx, got);
            check_word($sformatf("dbg_rsp.r_data @%h", 4 * idx),
                       program_word(idx, 16'h0001), got);
            idx = (idx == PROG_WORDS) ? 1 : idx + 1;
        end
        check_results(32'd1);
    endtask

    // watchdog
    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
        $display("checks: %0d errors: %0d", checks, errors);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        errors    = 0;
        checks    = 0;
        rng_state = 32'd92;
        arst_n    = 1'b0;
        start     = 1'b0;
        dbg_req   = '0;
        repeat (2) @(negedge clk);
        arst_n = 1'b1;
        test_reset_and_debug();
        test_builtin_program();
        test_sign_extension();
        test_early_halt();
        test_contention();
        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- mips_lite.f
verilog/mips_pkg.sv
verilog/unified_ram.sv
verilog/fetch_unit.sv
verilog/exec_core.sv
verilog/axi_lite_arbiter.sv
verilog/mips_lite_top.sv
verification/mips_lite_properties.sv
verification/tb_mips_lite.sv

//--- run_sim.sh
#!/bin/sh
# build and run the mips_lite testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f mips_lite.f --top-module tb_mips_lite \
    -o sim_mips_lite \
    && ./obj_dir/sim_mips_lite > sim.log 2>&1 \
    || { echo "build or simulation failed"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "^ALL CHECKS PASSED$" sim.log && echo "result: pass" \
    || { echo "result: fail"; exit 1; }
